// ==== logic/ct_params.svh ====
`ifndef CT_PARAMS_SVH
`define CT_PARAMS_SVH

// Number of channels sharing the link
`define CT_NUM_CHAN 4

// Payload width of one channel beat
`define CT_DATA_W 16

// Enough bits to name any channel
`define CT_CHAN_ID_W 2

// Far-end receive buffer depth, also the starting credit count
`define CT_REMOTE_CREDITS 4

// Holds 0 .. CT_REMOTE_CREDITS
`define CT_CREDIT_W 3

// Core-side input buffering per channel
`define CT_IN_DEPTH 2

`endif

// ==== logic/ct_pkg.sv ====
`include "ct_params.svh"

package ct_pkg;

  // Link word opcodes
  typedef enum logic
  {
    CT_OP_DATA   = 1'b0 // Payload for the named channel
  , CT_OP_CREDIT = 1'b1 // One credit back for the named channel
  } ct_op_e;

  // One word on the shared link, valid bit on top
  typedef struct packed
  {
    logic                      v;
    ct_op_e                    op;
    logic [`CT_CHAN_ID_W-1:0]  chan;
    logic [`CT_DATA_W-1:0]     data;
  } ct_word_s;

  // Core-side channel beat
  typedef struct packed
  {
    logic                      v;
    logic [`CT_DATA_W-1:0]     data;
  } ct_chan_s;

endpackage

// ==== logic/ct_chan_fifo.sv ====
`timescale 1ns/1ps

module ct_chan_fifo
#(parameter int width_p = 16
, parameter int depth_p = 2
)
( input  logic               core_clk_i
, input  logic               rst_n_i

, input  logic               v_i
, input  logic [width_p-1:0] data_i
, output logic               ready_o

, output logic               v_o
, output logic [width_p-1:0] data_o
, input  logic               yumi_i
);

  localparam int ptr_w_lp = (depth_p > 1) ? $clog2(depth_p) : 1;
  localparam int cnt_w_lp = $clog2(depth_p + 1);

  logic [width_p-1:0]  mem_r [depth_p];
  logic [ptr_w_lp-1:0] rd_ptr_r, wr_ptr_r;
  logic [cnt_w_lp-1:0] count_r;
  logic                full, wr_en, rd_en;

  assign full    = (count_r == cnt_w_lp'(depth_p));
  assign ready_o = ~full | yumi_i;      // A pop frees the slot this cycle
  assign wr_en   = v_i & ready_o;
  assign rd_en   = yumi_i;              // Caller only yumis while v_o is high

  assign v_o    = (count_r != '0);
  assign data_o = mem_r[rd_ptr_r];

  always_ff @(posedge core_clk_i)
  begin
    if (wr_en)
      mem_r[wr_ptr_r] <= data_i;
  end

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      rd_ptr_r <= '0;
      wr_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      // Pointers wrap at depth_p, which need not be a power of two
      if (wr_en)
        wr_ptr_r <= (wr_ptr_r == ptr_w_lp'(depth_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      if (rd_en)
        rd_ptr_r <= (rd_ptr_r == ptr_w_lp'(depth_p - 1)) ? '0 : rd_ptr_r + 1'b1;

      case ({wr_en, rd_en})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;     // Idle, or write and pop together
      endcase
    end
  end

endmodule

// ==== logic/ct_tunnel_mux.sv ====
`timescale 1ns/1ps
`include "ct_params.svh"

module ct_tunnel_mux
( input  logic                                     core_clk_i
, input  logic                                     rst_n_i

, input  logic [`CT_NUM_CHAN-1:0]                  fifo_v_i
, input  logic [`CT_NUM_CHAN-1:0][`CT_DATA_W-1:0]  fifo_data_i
, output logic [`CT_NUM_CHAN-1:0]                  fifo_yumi_o

, input  logic [`CT_NUM_CHAN-1:0]                  credit_ret_i
, input  logic [`CT_NUM_CHAN-1:0]                  credit_owed_i

, output ct_pkg::ct_word_s                         multi_o
, input  logic                                     multi_ready_i
);

  import ct_pkg::*;

  logic [`CT_NUM_CHAN-1:0][`CT_CREDIT_W-1:0] credit_r; // Space left at the far end
  logic [`CT_NUM_CHAN-1:0][`CT_CREDIT_W-1:0] owed_r;   // Credits still to send back
  logic [`CT_CHAN_ID_W-1:0]                  rr_r;     // Last channel chosen

  logic [`CT_NUM_CHAN-1:0]  owed_req, data_req;
  logic [`CT_NUM_CHAN-1:0]  credit_take, data_take;
  logic [`CT_CHAN_ID_W-1:0] owed_sel, data_sel, sel;
  logic                     load_en, issue, issue_credit;

  ct_word_s multi_r;

  // First requester after last, wrapping around
  function automatic logic [`CT_CHAN_ID_W-1:0] rr_pick
    (input logic [`CT_NUM_CHAN-1:0]  req
    ,input logic [`CT_CHAN_ID_W-1:0] last
    );
    logic [`CT_CHAN_ID_W-1:0] pick;
    int unsigned              idx;
    pick = last;
    for (int k = `CT_NUM_CHAN; k >= 1; k--)
    begin
      idx = (int'(last) + k) % `CT_NUM_CHAN;
      if (req[idx])
        pick = idx[`CT_CHAN_ID_W-1:0];
    end
    return pick;
  endfunction

  always_comb
  begin
    for (int i = 0; i < `CT_NUM_CHAN; i++)
    begin
      owed_req[i] = (owed_r[i] != '0);
      data_req[i] = fifo_v_i[i] & (credit_r[i] != '0);
    end

    owed_sel = rr_pick(owed_req, rr_r);
    data_sel = rr_pick(data_req, rr_r);

    load_en      = ~multi_r.v | multi_ready_i;  // Output slot empty or draining
    issue_credit = |owed_req;                   // Credit words go first
    issue        = load_en & (issue_credit | (|data_req));
    sel          = issue_credit ? owed_sel : data_sel;

    credit_take = '0;
    data_take   = '0;
    if (issue)
    begin
      if (issue_credit)
        credit_take[sel] = 1'b1;
      else
        data_take[sel] = 1'b1;
    end
  end

  assign fifo_yumi_o = data_take;
  assign multi_o     = multi_r;

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      multi_r.v <= 1'b0;
      rr_r      <= '0;
    end
    else if (load_en)
    begin
      multi_r.v <= issue;
      if (issue)
      begin
        multi_r.op   <= issue_credit ? CT_OP_CREDIT : CT_OP_DATA;
        multi_r.chan <= sel;
        multi_r.data <= issue_credit ? '0 : fifo_data_i[sel];
        rr_r         <= sel;
      end
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < `CT_NUM_CHAN; i++)
      begin
        credit_r[i] <= `CT_CREDIT_W'(`CT_REMOTE_CREDITS);
        owed_r[i]   <= '0;
      end
    end
    else
    begin
      for (int i = 0; i < `CT_NUM_CHAN; i++)
      begin
        case ({credit_ret_i[i], data_take[i]})
          2'b10:   credit_r[i] <= credit_r[i] + 1'b1;
          2'b01:   credit_r[i] <= credit_r[i] - 1'b1;
          default: credit_r[i] <= credit_r[i];
        endcase

        case ({credit_owed_i[i], credit_take[i]})
          2'b10:   owed_r[i] <= owed_r[i] + 1'b1;
          2'b01:   owed_r[i] <= owed_r[i] - 1'b1;
          default: owed_r[i] <= owed_r[i];
        endcase
      end
    end
  end

endmodule

// ==== logic/ct_tunnel_demux.sv ====
`timescale 1ns/1ps
`include "ct_params.svh"

module ct_tunnel_demux
( input  logic                         core_clk_i
, input  logic                         rst_n_i

, input  ct_pkg::ct_word_s             multi_i

, output logic [`CT_NUM_CHAN-1:0]      rx_wr_v_o
, output logic [`CT_DATA_W-1:0]        rx_wr_data_o
, output logic [`CT_NUM_CHAN-1:0]      credit_ret_o
);

  import ct_pkg::*;

  ct_word_s word_r;
  logic     in_range;
  logic     is_data;
  logic     is_credit;

  // Link has no back-pressure, take every valid word
  always_ff @(posedge core_clk_i)
  begin
    if (!rst_n_i)
      word_r.v <= 1'b0;
    else
    begin
      word_r.v <= multi_i.v;
      if (multi_i.v)
      begin
        word_r.op   <= multi_i.op;
        word_r.chan <= multi_i.chan;
        word_r.data <= multi_i.data;
      end
    end
  end

  // Ids past the channel count are dropped
  assign in_range = (int'(word_r.chan) < `CT_NUM_CHAN);

  assign is_data   = word_r.v & in_range & (word_r.op == CT_OP_DATA);
  assign is_credit = word_r.v & in_range & (word_r.op == CT_OP_CREDIT);

  always_comb
  begin
    for (int i = 0; i < `CT_NUM_CHAN; i++)
    begin
      rx_wr_v_o[i]    = is_data & (int'(word_r.chan) == i);
      credit_ret_o[i] = is_credit & (int'(word_r.chan) == i);
    end
  end

  assign rx_wr_data_o = word_r.data;   // Shared by all receive FIFOs

endmodule

// ==== logic/ct_link_top.sv ====
`timescale 1ns/1ps
`include "ct_params.svh"

module ct_link_top
( input  logic                                  core_clk_i
, input  logic                                  rst_n_i

, input  ct_pkg::ct_chan_s [`CT_NUM_CHAN-1:0]   chan_i
, output logic [`CT_NUM_CHAN-1:0]               chan_ready_o

, output ct_pkg::ct_chan_s [`CT_NUM_CHAN-1:0]   chan_o
, input  logic [`CT_NUM_CHAN-1:0]               chan_yumi_i

, output ct_pkg::ct_word_s                      multi_o
, input  logic                                  multi_ready_i

, input  ct_pkg::ct_word_s                      multi_i
);

  logic [`CT_NUM_CHAN-1:0]                 fifo_v;
  logic [`CT_NUM_CHAN-1:0][`CT_DATA_W-1:0] fifo_data;
  logic [`CT_NUM_CHAN-1:0]                 fifo_yumi;

  logic [`CT_NUM_CHAN-1:0]                 rx_wr_v;
  logic [`CT_DATA_W-1:0]                   rx_wr_data;
  logic [`CT_NUM_CHAN-1:0]                 credit_ret;

  for (genvar i = 0; i < `CT_NUM_CHAN; i++)
  begin: in_ch
    ct_chan_fifo #(.width_p(`CT_DATA_W), .depth_p(`CT_IN_DEPTH))
      in_fifo
        (.core_clk_i ( core_clk_i )
        ,.rst_n_i    ( rst_n_i )
        ,.v_i        ( chan_i[i].v )
        ,.data_i     ( chan_i[i].data )
        ,.ready_o    ( chan_ready_o[i] )
        ,.v_o        ( fifo_v[i] )
        ,.data_o     ( fifo_data[i] )
        ,.yumi_i     ( fifo_yumi[i] )
        );
  end: in_ch

  ct_tunnel_mux
    mux
      (.core_clk_i    ( core_clk_i )
      ,.rst_n_i       ( rst_n_i )
      ,.fifo_v_i      ( fifo_v )
      ,.fifo_data_i   ( fifo_data )
      ,.fifo_yumi_o   ( fifo_yumi )
      ,.credit_ret_i  ( credit_ret )
      ,.credit_owed_i ( chan_yumi_i )  // Each core pop owes the far side a credit
      ,.multi_o       ( multi_o )
      ,.multi_ready_i ( multi_ready_i )
      );

  ct_tunnel_demux
    demux
      (.core_clk_i   ( core_clk_i )
      ,.rst_n_i      ( rst_n_i )
      ,.multi_i      ( multi_i )
      ,.rx_wr_v_o    ( rx_wr_v )
      ,.rx_wr_data_o ( rx_wr_data )
      ,.credit_ret_o ( credit_ret )
      );

  // Credits guarantee space, so receive ready is never consulted
  for (genvar i = 0; i < `CT_NUM_CHAN; i++)
  begin: rx_ch
    ct_chan_fifo #(.width_p(`CT_DATA_W), .depth_p(`CT_REMOTE_CREDITS))
      rx_fifo
        (.core_clk_i ( core_clk_i )
        ,.rst_n_i    ( rst_n_i )
        ,.v_i        ( rx_wr_v[i] )
        ,.data_i     ( rx_wr_data )
        ,.ready_o    ()
        ,.v_o        ( chan_o[i].v )
        ,.data_o     ( chan_o[i].data )
        ,.yumi_i     ( chan_yumi_i[i] )
        );
  end: rx_ch

endmodule

// ==== bench/ct_props.sv ====
`timescale 1ns/1ps
`include "ct_params.svh"

module ct_props
( input  logic                                       core_clk_i
, input  logic                                       rst_n_i
, input  logic [`CT_NUM_CHAN-1:0][`CT_CREDIT_W-1:0]  credit_i
, input  ct_pkg::ct_word_s                           link_word_i
, input  logic                                       link_ready_i
);

  import ct_pkg::*;

  for (genvar i = 0; i < `CT_NUM_CHAN; i++)
  begin: per_ch
    // Far end never holds more than its buffer depth
    credit_bound_a: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
      credit_i[i] <= `CT_CREDIT_W'(`CT_REMOTE_CREDITS))
      else $error("Credit counter of channel %0d above buffer depth", i);

    // A fresh data word needs credit in the cycle it was chosen
    credit_gate_a: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
      (link_word_i.v && link_word_i.op == CT_OP_DATA && link_word_i.chan == i
       && (!$past(link_word_i.v) || $past(link_ready_i)))
      |-> ($past(credit_i[i]) != '0))
      else $error("Data word for channel %0d issued without credit", i);
  end: per_ch

  // Held word stays put until the link takes it
  link_hold_a: assert property (@(posedge core_clk_i) disable iff (!rst_n_i)
    (link_word_i.v && !link_ready_i) |=> $stable(link_word_i))
    else $error("Link word changed while link was stalled");

endmodule

bind ct_tunnel_mux ct_props props_i
  (.core_clk_i   ( core_clk_i )
  ,.rst_n_i      ( rst_n_i )
  ,.credit_i     ( credit_r )
  ,.link_word_i  ( multi_o )
  ,.link_ready_i ( multi_ready_i )
  );

// ==== bench/ct_tb.sv ====
`timescale 1ns/1ps
`include "ct_params.svh"

module ct_tb;

  import ct_pkg::*;

  typedef struct packed
  {
    logic [`CT_NUM_CHAN-1:0] mask;   // Channels that send
    logic [7:0]              len;    // Beats per channel
    logic [7:0]              duty;   // Percent of cycles the link is ready
    logic [`CT_NUM_CHAN-1:0] hold;   // Channels whose pops are withheld
    logic                    stall;  // Input ready expected to drop
  } row_s;

  localparam int n_rows_lp     = 4;
  localparam int wait_limit_lp = 2000;

  logic                                clk = 1'b0;
  logic                                rst_n;
  ct_chan_s [`CT_NUM_CHAN-1:0]         chan_in;
  logic [`CT_NUM_CHAN-1:0]             chan_ready;
  ct_chan_s [`CT_NUM_CHAN-1:0]         chan_out;
  logic [`CT_NUM_CHAN-1:0]             chan_yumi;
  ct_word_s                            multi_out;
  ct_word_s                            multi_back;
  logic                                multi_ready;

  row_s                  rows [n_rows_lp];
  row_s                  cur;
  logic [`CT_DATA_W-1:0] exp_q [`CT_NUM_CHAN][$];
  logic [`CT_DATA_W-1:0] payload [`CT_NUM_CHAN];
  int                    sent [`CT_NUM_CHAN];
  int                    rcvd [`CT_NUM_CHAN];
  int                    link_data [`CT_NUM_CHAN]; // Data words taken by the link
  logic                  saw_stall;
  int                    mismatch_cnt;
  int                    timeout_cnt;
  int                    check_cnt;

  always #4 clk = ~clk;

  // The link carries a word only on the cycle it is consumed
  always_comb
  begin
    multi_back   = multi_out;
    multi_back.v = multi_out.v & multi_ready;
  end

  ct_link_top ct_link_top_i
    (.core_clk_i    ( clk )
    ,.rst_n_i       ( rst_n )
    ,.chan_i        ( chan_in )
    ,.chan_ready_o  ( chan_ready )
    ,.chan_o        ( chan_out )
    ,.chan_yumi_i   ( chan_yumi )
    ,.multi_o       ( multi_out )
    ,.multi_ready_i ( multi_ready )
    ,.multi_i       ( multi_back )
    );

  task automatic load_table();
    rows[0] = {4'hF, 8'd8,  8'd100, 4'h0, 1'b0}; // All channels, free link
    rows[1] = {4'hF, 8'd12, 8'd25,  4'h0, 1'b1}; // Link mostly stalled
    rows[2] = {4'hF, 8'd10, 8'd100, 4'h2, 1'b0}; // Channel 1 not popped
    rows[3] = {4'hD, 8'd6,  8'd60,  4'h8, 1'b0};
  endtask

  // One cycle: drive at the falling edge, then look at what the next edge takes
  task automatic drive_cycle();
    logic [`CT_DATA_W-1:0] exp_word;
    @(negedge clk);
    for (int i = 0; i < `CT_NUM_CHAN; i++)
    begin
      chan_in[i].v    = cur.mask[i] && (sent[i] < int'(cur.len));
      chan_in[i].data = payload[i];
      chan_yumi[i]    = chan_out[i].v & ~cur.hold[i];
    end
    multi_ready = (int'($urandom % 100) < int'(cur.duty));
    #1;
    if (chan_ready != '1)
      saw_stall = 1'b1;
    if (multi_out.v && multi_ready && multi_out.op == CT_OP_DATA)
      link_data[multi_out.chan]++;
    for (int i = 0; i < `CT_NUM_CHAN; i++)
    begin
      if (chan_in[i].v && chan_ready[i])
      begin
        exp_q[i].push_back(payload[i]);
        sent[i]++;
        payload[i] = `CT_DATA_W'($urandom);
      end
      if (chan_yumi[i])
      begin
        rcvd[i]++;
        if (exp_q[i].size() == 0)
        begin
          $display("MISMATCH at %0t: channel %0d delivered %h with nothing outstanding",
                   $time, i, chan_out[i].data);
          mismatch_cnt++;
        end
        else
        begin
          exp_word = exp_q[i].pop_front();
          if (chan_out[i].data !== exp_word)
          begin
            $display("MISMATCH at %0t: channel %0d got %h, expected %h",
                     $time, i, chan_out[i].data, exp_word);
            mismatch_cnt++;
          end
        end
      end
    end
  endtask

  function automatic logic delivered_all(input logic [`CT_NUM_CHAN-1:0] skip);
    for (int i = 0; i < `CT_NUM_CHAN; i++)
      if (cur.mask[i] && !skip[i] && rcvd[i] < int'(cur.len))
        return 1'b0;
    return 1'b1;
  endfunction

  function automatic logic held_at_limit();
    for (int i = 0; i < `CT_NUM_CHAN; i++)
      if (cur.mask[i] && cur.hold[i] && link_data[i] < `CT_REMOTE_CREDITS)
        return 1'b0;
    return 1'b1;
  endfunction

  task automatic wait_delivery(input logic [`CT_NUM_CHAN-1:0] skip, input string what);
    int n;
    n = 0;
    while (!delivered_all(skip) && n < wait_limit_lp)
    begin
      drive_cycle();
      n++;
    end
    if (!delivered_all(skip))
    begin
      $display("Timeout at %0t waiting for %s to deliver", $time, what);
      timeout_cnt++;
    end
  endtask

  task automatic wait_held_limit();
    int n;
    n = 0;
    while (!held_at_limit() && n < wait_limit_lp)
    begin
      drive_cycle();
      n++;
    end
    if (!held_at_limit())
    begin
      $display("Timeout at %0t waiting for held channels to use up their credits", $time);
      timeout_cnt++;
    end
  endtask

  task automatic check_reset_state();
    if (multi_out.v !== 1'b0)
    begin
      $display("MISMATCH at %0t: link word valid right after reset", $time);
      mismatch_cnt++;
    end
    for (int i = 0; i < `CT_NUM_CHAN; i++)
    begin
      if (chan_out[i].v !== 1'b0 || chan_ready[i] !== 1'b1)
      begin
        $display("MISMATCH at %0t: channel %0d out valid %b, ready %b after reset",
                 $time, i, chan_out[i].v, chan_ready[i]);
        mismatch_cnt++;
      end
    end
  endtask

  task automatic run_row(input row_s r);
    cur       = r;
    saw_stall = 1'b0;
    for (int i = 0; i < `CT_NUM_CHAN; i++)
    begin
      sent[i]      = 0;
      rcvd[i]      = 0;
      link_data[i] = 0;
    end
    wait_delivery(cur.hold, "unheld channels");
    if (|(cur.hold & cur.mask))
    begin
      wait_held_limit();
      repeat (32) drive_cycle();   // No further held word may cross the link
      for (int i = 0; i < `CT_NUM_CHAN; i++)
      begin
        if (cur.mask[i] && cur.hold[i])
        begin
          if (link_data[i] != `CT_REMOTE_CREDITS || chan_out[i].v !== 1'b1)
          begin
            $display("MISMATCH at %0t: held channel %0d sent %0d words, out valid %b",
                     $time, i, link_data[i], chan_out[i].v);
            mismatch_cnt++;
          end
        end
      end
      cur.hold = '0;               // Pops resume and credits flow back
      wait_delivery('0, "released channels");
    end
    if (cur.stall && !saw_stall)
    begin
      $display("Input ready never dropped while the link was stalled");
      check_cnt++;
    end
  endtask

  initial
  begin
    void'($urandom(37073));
    rst_n        = 1'b0;
    chan_in      = '0;
    chan_yumi    = '0;
    multi_ready  = 1'b0;
    cur          = '0;
    saw_stall    = 1'b0;
    mismatch_cnt = 0;
    timeout_cnt  = 0;
    check_cnt    = 0;
    for (int i = 0; i < `CT_NUM_CHAN; i++)
      payload[i] = `CT_DATA_W'($urandom);
    load_table();

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    check_reset_state();

    for (int r = 0; r < n_rows_lp; r++)
      run_row(rows[r]);

    for (int i = 0; i < `CT_NUM_CHAN; i++)
    begin
      if (exp_q[i].size() != 0)
      begin
        $display("Channel %0d still has %0d words that never arrived", i, exp_q[i].size());
        check_cnt++;
      end
    end

    $display("Errors: %0d mismatches, %0d timeouts, %0d failed checks",
             mismatch_cnt, timeout_cnt, check_cnt);
    if (mismatch_cnt + timeout_cnt + check_cnt == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+logic
logic/ct_pkg.sv
logic/ct_chan_fifo.sv
logic/ct_tunnel_mux.sv
logic/ct_tunnel_demux.sv
logic/ct_link_top.sv
bench/ct_props.sv
bench/ct_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the loopback testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert -j 0 -f files.f \
  --top-module ct_tb -Mdir obj_dir -o ct_sim \
  || { echo "Build failed"; exit 1; }

./obj_dir/ct_sim > "$log" 2>&1
cat "$log"

grep -q "STATUS: FAIL" "$log" && { echo "Simulation failed"; exit 1; }
grep -q "STATUS: PASS" "$log" || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
exit 0
